// ==== line_read_settings.svh ====
`ifndef LINE_READ_SETTINGS_SVH
`define LINE_READ_SETTINGS_SVH

// Byte address width on both the core and the level-two side
`define RL_ADDR_W 32

// Core read data width, wide enough for the largest access size
`define RL_DATA_W 32

// One level-two line
`define RL_LINE_BYTES 16
`define RL_LINE_W 128

// Burst length field, holds the number of beats minus one
`define RL_LEN_W 8

// Largest supported access size code (word)
`define RL_MAX_SIZE 2

`endif

// ==== line_read_pkg.sv ====
`include "line_read_settings.svh"

package line_read_pkg;

   // Read sequencer states
   typedef enum logic [1:0] {
      read_idle,
      read_fetch,
      read_wait_line,
      read_beat_out
   } read_state_e;

   // Access size codes, element bytes are 1 << code
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } access_size_e;

   typedef logic [`RL_LINE_W-1:0] line_t;

   // Index of a byte within the line, the narrowest element
   typedef logic [$clog2(`RL_LINE_BYTES)-1:0] word_index_t;

   typedef logic [`RL_ADDR_W-1:0] line_addr_t;

endpackage

// ==== beat_ctrl_if.sv ====
`timescale 1ns/1ps

// Control between the read FSM, the beat counter and the line buffer
interface beat_ctrl_if;

   // Accepted transfers, one cycle each
   logic load;
   logic capture;
   logic advance;

   // Burst position as seen by the FSM
   logic last_beat;
   logic line_end;

   // Element selection for the line buffer
   line_read_pkg::word_index_t word_index;
   line_read_pkg::access_size_e size;

   modport fsm (
      output load, capture, advance,
      input  last_beat, line_end
   );

   modport counter (
      input  load, advance,
      output last_beat, line_end, word_index, size
   );

   modport buffer (
      input word_index, size, capture
   );

endinterface

// ==== line_read_fsm.sv ====
`timescale 1ns/1ps

module line_read_fsm (
   input  logic clk,
   input  logic rstn,
   beat_ctrl_if.fsm ctrl,
   input  logic ar_valid,
   input  logic l2_ar_ready,
   input  logic l2_r_valid,
   input  logic r_ready,
   output logic ar_ready,
   output logic l2_ar_valid,
   output logic l2_r_ready,
   output logic r_valid,
   output logic r_last
);

   line_read_pkg::read_state_e state;
   line_read_pkg::read_state_e next_state;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= line_read_pkg::read_idle;
      end else begin
         state <= next_state;
      end
   end

   // Each handshake signal belongs to exactly one state
   assign ar_ready    = (state == line_read_pkg::read_idle);
   assign l2_ar_valid = (state == line_read_pkg::read_fetch);
   assign l2_r_ready  = (state == line_read_pkg::read_wait_line);
   assign r_valid     = (state == line_read_pkg::read_beat_out);
   assign r_last      = r_valid && ctrl.last_beat;

   assign ctrl.load    = ar_valid && ar_ready;
   assign ctrl.capture = l2_r_valid && l2_r_ready;
   assign ctrl.advance = r_valid && r_ready;

   always_comb begin
      next_state = state;
      case (state)
         line_read_pkg::read_idle: begin
            if (ar_valid) begin
               next_state = line_read_pkg::read_fetch;
            end
         end
         line_read_pkg::read_fetch: begin
            if (l2_ar_ready) begin
               next_state = line_read_pkg::read_wait_line;
            end
         end
         line_read_pkg::read_wait_line: begin
            if (l2_r_valid) begin
               next_state = line_read_pkg::read_beat_out;
            end
         end
         line_read_pkg::read_beat_out: begin
            // Refetch only when the burst walks off the buffered line
            if (r_ready) begin
               if (ctrl.last_beat) begin
                  next_state = line_read_pkg::read_idle;
               end else if (ctrl.line_end) begin
                  next_state = line_read_pkg::read_fetch;
               end
            end
         end
         default: begin
            next_state = line_read_pkg::read_idle;
         end
      endcase
   end

endmodule

// ==== beat_counter.sv ====
`timescale 1ns/1ps
`include "line_read_settings.svh"

module beat_counter (
   input  logic clk,
   input  logic rstn,
   beat_ctrl_if.counter ctrl,
   input  line_read_pkg::line_addr_t ar_addr,
   input  line_read_pkg::access_size_e ar_size,
   input  logic [`RL_LEN_W-1:0] ar_len,
   output line_read_pkg::line_addr_t l2_ar_addr
);

   localparam int OFS_W = $clog2(`RL_LINE_BYTES);

   line_read_pkg::access_size_e size_q;
   line_read_pkg::access_size_e load_size;
   logic [`RL_LEN_W-1:0] remain_q;
   line_read_pkg::word_index_t index_q;
   line_read_pkg::word_index_t index_limit;
   line_read_pkg::line_addr_t line_addr_q;

   // Codes above the largest supported size are read as the largest one
   assign load_size = (ar_size > `RL_MAX_SIZE) ?
                      line_read_pkg::access_size_e'(`RL_MAX_SIZE) : ar_size;

   // Index of the last element of the current size within one line
   always_comb begin
      case (size_q)
         line_read_pkg::size_byte:
            index_limit = line_read_pkg::word_index_t'(`RL_LINE_BYTES - 1);
         line_read_pkg::size_half:
            index_limit = line_read_pkg::word_index_t'(`RL_LINE_BYTES / 2 - 1);
         line_read_pkg::size_word:
            index_limit = line_read_pkg::word_index_t'(`RL_LINE_BYTES / 4 - 1);
         default:
            index_limit = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         size_q      <= line_read_pkg::size_byte;
         remain_q    <= '0;
         index_q     <= '0;
         line_addr_q <= '0;
      end else if (ctrl.load) begin
         size_q   <= load_size;
         remain_q <= ar_len;
         // Start element is the in-line offset counted in elements
         index_q  <= line_read_pkg::word_index_t'(ar_addr[OFS_W-1:0] >> load_size);
         line_addr_q <= {ar_addr[`RL_ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
      end else if (ctrl.advance && !ctrl.last_beat) begin
         remain_q <= remain_q - 1'b1;
         if (ctrl.line_end) begin
            index_q     <= '0;
            line_addr_q <= line_addr_q + line_read_pkg::line_addr_t'(`RL_LINE_BYTES);
         end else begin
            index_q <= index_q + 1'b1;
         end
      end
   end

   assign ctrl.last_beat  = (remain_q == '0);
   assign ctrl.line_end   = (index_q == index_limit);
   assign ctrl.word_index = index_q;
   assign ctrl.size       = size_q;

   assign l2_ar_addr = line_addr_q;

endmodule

// ==== line_buffer.sv ====
`timescale 1ns/1ps
`include "line_read_settings.svh"

module line_buffer (
   input  logic clk,
   input  logic rstn,
   beat_ctrl_if.buffer ctrl,
   input  line_read_pkg::line_t l2_r_data,
   output logic [`RL_DATA_W-1:0] r_data
);

   localparam int OFS_W = $clog2(`RL_LINE_BYTES);

   line_read_pkg::line_t line_q;
   logic [OFS_W-1:0] byte_sel;
   logic [OFS_W-2:0] half_sel;
   logic [OFS_W-3:0] word_sel;

   // Line register, loaded on each accepted level-two response
   always_ff @(posedge clk) begin
      if (!rstn) begin
         line_q <= '0;
      end else if (ctrl.capture) begin
         line_q <= l2_r_data;
      end
   end

   // The counter keeps the index within the element count of the line,
   // so only the low index bits matter for the wider sizes
   assign byte_sel = ctrl.word_index;
   assign half_sel = ctrl.word_index[OFS_W-2:0];
   assign word_sel = ctrl.word_index[OFS_W-3:0];

   always_comb begin
      r_data = '0;
      case (ctrl.size)
         line_read_pkg::size_byte: begin
            r_data[7:0] = line_q[byte_sel*8 +: 8];
         end
         line_read_pkg::size_half: begin
            r_data[15:0] = line_q[half_sel*16 +: 16];
         end
         line_read_pkg::size_word: begin
            r_data[31:0] = line_q[word_sel*32 +: 32];
         end
         default: begin
            r_data = '0;
         end
      endcase
   end

endmodule

// ==== line_read_top.sv ====
`timescale 1ns/1ps
`include "line_read_settings.svh"

// Cache-line read adapter. A narrow core burst is served from single
// line-wide level-two fetches, one fetch per line the burst touches
module line_read_top (
   input  logic clk,
   input  logic rstn,

   // Core read request
   input  logic ar_valid,
   output logic ar_ready,
   input  line_read_pkg::line_addr_t ar_addr,
   input  line_read_pkg::access_size_e ar_size,
   input  logic [`RL_LEN_W-1:0] ar_len,

   // Core read data
   output logic r_valid,
   input  logic r_ready,
   output logic [`RL_DATA_W-1:0] r_data,
   output logic r_last,

   // Level-two line request
   output logic l2_ar_valid,
   input  logic l2_ar_ready,
   output line_read_pkg::line_addr_t l2_ar_addr,

   // Level-two line data
   input  logic l2_r_valid,
   output logic l2_r_ready,
   input  line_read_pkg::line_t l2_r_data
);

   beat_ctrl_if ctrl ();

   // Sequencing and all handshakes
   line_read_fsm u_fsm (
      .clk         (clk),
      .rstn        (rstn),
      .ctrl        (ctrl.fsm),
      .ar_valid    (ar_valid),
      .l2_ar_ready (l2_ar_ready),
      .l2_r_valid  (l2_r_valid),
      .r_ready     (r_ready),
      .ar_ready    (ar_ready),
      .l2_ar_valid (l2_ar_valid),
      .l2_r_ready  (l2_r_ready),
      .r_valid     (r_valid),
      .r_last      (r_last)
   );

   // Burst position and the line address to fetch
   beat_counter u_counter (
      .clk        (clk),
      .rstn       (rstn),
      .ctrl       (ctrl.counter),
      .ar_addr    (ar_addr),
      .ar_size    (ar_size),
      .ar_len     (ar_len),
      .l2_ar_addr (l2_ar_addr)
   );

   // Holds the fetched line and picks out each core beat
   line_buffer u_buffer (
      .clk       (clk),
      .rstn      (rstn),
      .ctrl      (ctrl.buffer),
      .l2_r_data (l2_r_data),
      .r_data    (r_data)
   );

endmodule

// ==== tb_line_read.sv ====
`timescale 1ns/1ps
`include "line_read_settings.svh"

module tb_line_read;

   logic clk;
   logic rstn = 1'b0;
   logic ar_valid = 1'b0;
   logic ar_ready;
   line_read_pkg::line_addr_t ar_addr = '0;
   line_read_pkg::access_size_e ar_size = line_read_pkg::size_byte;
   logic [`RL_LEN_W-1:0] ar_len = '0;
   logic r_valid;
   logic r_ready = 1'b0;
   logic [`RL_DATA_W-1:0] r_data;
   logic r_last;
   logic l2_ar_valid;
   logic l2_ar_ready = 1'b0;
   line_read_pkg::line_addr_t l2_ar_addr;
   logic l2_r_valid = 1'b0;
   logic l2_r_ready;
   line_read_pkg::line_t l2_r_data = '0;

   // Request records and the flat list of expected beats
   logic [31:0] req_addr[$];
   logic [1:0] req_size[$];
   logic [`RL_LEN_W-1:0] req_len[$];
   logic [31:0] req_fetches[$];
   int beat_base[$];
   logic [31:0] exp_beats[$];
   logic [31:0] fetch_log[$];

   logic [31:0] lfsr_state = 32'h70d9_df19;
   logic resp_go = 1'b0;
   logic line_pending = 1'b0;
   logic [31:0] pending_addr = '0;
   int error_count = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int cycle_count = 0;
   int timeout_limit = 0;
   bit stim_ok;

   line_read_top DUT (
      .clk         (clk),
      .rstn        (rstn),
      .ar_valid    (ar_valid),
      .ar_ready    (ar_ready),
      .ar_addr     (ar_addr),
      .ar_size     (ar_size),
      .ar_len      (ar_len),
      .r_valid     (r_valid),
      .r_ready     (r_ready),
      .r_data      (r_data),
      .r_last      (r_last),
      .l2_ar_valid (l2_ar_valid),
      .l2_ar_ready (l2_ar_ready),
      .l2_ar_addr  (l2_ar_addr),
      .l2_r_valid  (l2_r_valid),
      .l2_r_ready  (l2_r_ready),
      .l2_r_data   (l2_r_data)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Fibonacci LFSR with taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Memory byte is the XOR of all four address bytes and 5A
   function automatic line_read_pkg::line_t line_data(input logic [31:0] base);
      line_read_pkg::line_t line;
      logic [31:0] a;
      int i;
      line = '0;
      for (i = 0; i < `RL_LINE_BYTES; i++) begin
         a = base + 32'(i);
         line[i*8 +: 8] = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;
      end
      return line;
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         error_count++;
      end
   endtask

   // One LFSR bit per stall decision, every cycle
   always @(posedge clk) begin
      lfsr_state = lfsr_step(lfsr_state);
      l2_ar_ready <= lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
      resp_go <= lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
      r_ready <= lfsr_state[0];
   end

   // Level-two responder. Once raised, l2_r_valid holds until the line is taken
   always @(posedge clk) begin
      if (!rstn) begin
         l2_r_valid <= 1'b0;
         line_pending <= 1'b0;
      end else begin
         if (l2_ar_valid && l2_ar_ready) begin
            fetch_log.push_back(l2_ar_addr);
            pending_addr <= l2_ar_addr;
            line_pending <= 1'b1;
         end
         if (l2_r_valid && l2_r_ready) begin
            l2_r_valid <= 1'b0;
            line_pending <= 1'b0;
         end else if (line_pending && !l2_r_valid && resp_go) begin
            l2_r_valid <= 1'b1;
            l2_r_data <= line_data(pending_addr);
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // Returns the next line that holds data, skipping comment and blank lines
   task automatic read_data_line(input int fd, output string line, output bit found);
      string raw;
      logic [31:0] probe;
      int n;
      found = 0;
      line = "";
      while (!found && !$feof(fd)) begin
         n = $fgets(raw, fd);
         if (n > 0 && raw.getc(0) != "#" && $sscanf(raw, "%h", probe) == 1) begin
            line = raw;
            found = 1;
         end
      end
   endtask

   task automatic load_stimulus(output bit ok);
      int fd;
      int k;
      string line;
      bit found;
      logic [31:0] a, s, l, f, b;
      ok = 1;
      fd = $fopen("line_read_stimulus.txt", "r");
      if (fd == 0) begin
         ok = 0;
      end else begin
         read_data_line(fd, line, found);
         while (found && ok) begin
            if ($sscanf(line, "%h %h %h %h", a, s, l, f) != 4) begin
               ok = 0;
            end else begin
               req_addr.push_back(a);
               req_size.push_back(s[1:0]);
               req_len.push_back(l[`RL_LEN_W-1:0]);
               req_fetches.push_back(f);
               beat_base.push_back(exp_beats.size());
               for (k = 0; k <= int'(l) && ok; k++) begin
                  read_data_line(fd, line, found);
                  if (!found || $sscanf(line, "%h", b) != 1) begin
                     ok = 0;
                  end else begin
                     exp_beats.push_back(b);
                  end
               end
               read_data_line(fd, line, found);
            end
         end
         $fclose(fd);
      end
      if (req_addr.size() == 0) begin
         ok = 0;
      end
   endtask

   task automatic run_request(input int idx);
      logic [31:0] addr;
      logic held_last;
      logic [31:0] held_data;
      int len, base, fetch_start, beat, k, errors_before;
      bit done, hold_armed;
      errors_before = error_count;
      addr = req_addr[idx];
      len = int'(req_len[idx]);
      base = beat_base[idx];
      fetch_start = fetch_log.size();
      @(posedge clk);
      ar_valid <= 1'b1;
      ar_addr <= addr;
      ar_size <= line_read_pkg::access_size_e'(req_size[idx]);
      ar_len <= req_len[idx];
      @(posedge clk);
      while (!(ar_valid && ar_ready)) begin
         @(posedge clk);
      end
      ar_valid <= 1'b0;
      beat = 0;
      done = 0;
      hold_armed = 0;
      held_data = '0;
      held_last = 1'b0;
      while (!done) begin
         @(posedge clk);
         // A stalled beat must not move until the core takes it
         if (hold_armed) begin
            check_value({31'b0, r_valid}, 32'd1, "r_valid dropped while r_ready was low");
            check_value(r_data, held_data, "r_data changed while r_ready was low");
            check_value({31'b0, r_last}, {31'b0, held_last}, "r_last changed under stall");
         end
         hold_armed = r_valid && !r_ready;
         held_data = r_data;
         held_last = r_last;
         if (r_valid && r_ready) begin
            check_value(r_data, exp_beats[base + beat], $sformatf("beat %0d data", beat));
            check_value({31'b0, r_last}, (beat == len) ? 32'd1 : 32'd0,
                        $sformatf("beat %0d r_last", beat));
            done = r_last || (beat == len);
            beat++;
         end
      end
      check_value(32'(fetch_log.size() - fetch_start), req_fetches[idx], "level-two fetch count");
      for (k = fetch_start; k < fetch_log.size(); k++) begin
         check_value(fetch_log[k] & 32'(`RL_LINE_BYTES - 1), 32'd0, "line address alignment");
         if (k == fetch_start) begin
            check_value(fetch_log[k], addr & ~32'(`RL_LINE_BYTES - 1), "first line address");
         end else begin
            check_value(fetch_log[k], fetch_log[k-1] + 32'(`RL_LINE_BYTES), "line address step");
         end
      end
      if (error_count == errors_before) begin
         tests_passed++;
      end else begin
         tests_failed++;
      end
      $display("Test %0d: addr %h size %0d beats %0d: %s", idx + 1, addr, req_size[idx],
               len + 1, (error_count == errors_before) ? "ok" : "failed");
   endtask

   initial begin
      int i;
      int errors_before;
      load_stimulus(stim_ok);
      if (stim_ok) begin
         timeout_limit = exp_beats.size() * 40 + 200;
         repeat (2) @(posedge clk);
         rstn <= 1'b1;
         @(posedge clk);
         errors_before = error_count;
         check_value({31'b0, ar_ready}, 32'd1, "ar_ready after reset");
         check_value({31'b0, r_valid}, 32'd0, "r_valid after reset");
         check_value({31'b0, r_last}, 32'd0, "r_last after reset");
         check_value({31'b0, l2_ar_valid}, 32'd0, "l2_ar_valid after reset");
         check_value({31'b0, l2_r_ready}, 32'd0, "l2_r_ready after reset");
         if (error_count == errors_before) begin
            tests_passed++;
         end else begin
            tests_failed++;
         end
         $display("Test 0: reset state: %s", (error_count == errors_before) ? "ok" : "failed");
         for (i = 0; i < req_addr.size(); i++) begin
            run_request(i);
         end
         $display("Tests: %0d ok, %0d failed, %0d errors", tests_passed, tests_failed,
                  error_count);
         if (error_count == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
         end else begin
            $display("SOME TESTS FAILED");
         end
      end else begin
         $display("The stimulus file line_read_stimulus.txt is missing or malformed");
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== line_read_stimulus.txt ====
# Record line: addr size len fetches (hex), len is beats minus one
# Then len+1 lines of expected beats; memory byte = XOR of address bytes ^ 5A
00000000 2 0 1
59585b5a
00000004 0 3 1
5e
5f
5c
5d
00000008 1 3 1
5352
5150
5756
5554
00000018 2 4 2
41404342
45444746
79787b7a
7d7c7f7e
71707372
000000fe 0 3 2
a4
a5
5b
5a
000001fd 1 a 3
a6a7
a4a5
5958
5b5a
5d5c
5f5e
5150
5352
5554
5756
4948

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the line read adapter testbench with Verilator and runs it.
# The run counts as failed when the log holds the fail message.
set -e

cd "$(dirname "$0")"

log=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
   --top-module tb_line_read \
   -f build.f \
   -Mdir obj_dir

./obj_dir/Vtb_line_read > "$log" 2>&1
cat "$log"

if grep -q "SOME TESTS FAILED" "$log"; then
   echo "Simulation reported failures, see $log"
   exit 1
fi

if ! grep -q "ALL TESTS PASSED" "$log"; then
   echo "Simulation ended without a result line, see $log"
   exit 1
fi

// ==== build.f ====
+incdir+.
line_read_pkg.sv
beat_ctrl_if.sv
line_read_fsm.sv
beat_counter.sv
line_buffer.sv
line_read_top.sv
tb_line_read.sv
